/* compile.f */
src/policer_pkg.sv
src/policer_regs_pkg.sv
src/policer_csr.sv
src/ingress_policer.sv
src/drop_filter.sv
src/policer_top.sv
dv/policer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the policer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module policer_tb \
    -o policer_sim \
    && ./obj_dir/policer_sim | grep "^Verification passed$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* dv/policer_tb.sv */
// ======================================================================
// Testbench for the ingress policing stage: stimulus, model and checks.
// ======================================================================

`timescale 1ns/10ps

module policer_tb
    import policer_pkg::*;
    import policer_regs_pkg::*;
;

    // Upper bounds used for the cycle limit.
    localparam int num_pkts  = 100;
    localparam int max_beats = num_pkts * 6;
    localparam int num_wb    = 50;
    localparam int cycle_lim = 2 * max_beats + 4 * num_wb + 500;

    logic               packet_in;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    logic [data_w-1:0]  in_data;
    logic               in_last;
    logic [port_w-1:0]  in_port;
    logic [len_w-1:0]   in_length;
    logic               out_valid;
    logic               out_ready;
    logic [data_w-1:0]  out_data;
    logic               out_last;
    logic [port_w-1:0]  out_port;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [adr_w-1:0]   wb_adr;
    logic [cnt_w-1:0]   wb_wdata;
    logic [cnt_w-1:0]   wb_rdata;
    logic               wb_ack;

    logic [31:0]        stim_seed;
    logic [31:0]        ready_seed;
    logic               random_ready;
    int                 cycles;

    // Reference model state.
    logic [len_w-1:0]   m_level [num_ports];
    logic               m_en    [num_ports];
    logic [len_w-1:0]   m_dec   [num_ports];
    logic [len_w-1:0]   m_thr   [num_ports];
    logic               m_body;
    logic               m_mark;
    logic [port_w-1:0]  m_port;
    int                 m_drops;
    int                 m_passes;
    logic [data_w+port_w:0] exp_q [$];     // {data, last, port}.

    policer_top uut (
        .packet_in, .rst_n,
        .in_valid, .in_ready, .in_data, .in_last, .in_port, .in_length,
        .out_valid, .out_ready, .out_data, .out_last, .out_port,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack
    );

    always #10 packet_in = ~packet_in;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [len_w-1:0] drain(input logic [len_w:0] lvl,
                                               input logic [len_w-1:0] dec);
        return (lvl > {1'b0, dec}) ? len_w'(lvl - {1'b0, dec}) : '0;
    endfunction

    task automatic report_fail(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // ==================================================================
    // Wishbone master
    // ==================================================================

    task automatic wb_access(input logic we, input logic [adr_w-1:0] adr,
                             input logic [cnt_w-1:0] wdata, output logic [cnt_w-1:0] rdata);
        int waits;
        waits = 0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        @(posedge packet_in);
        while (!wb_ack) begin
            waits++;
            assert (waits < 10) else report_fail("no wb_ack within 10 cycles");
            @(posedge packet_in);
        end
        rdata  = wb_rdata;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge packet_in);
        assert (!wb_ack) else report_fail("wb_ack held longer than one cycle");
    endtask

    task automatic wb_write(input logic [adr_w-1:0] adr, input logic [cnt_w-1:0] data);
        logic [cnt_w-1:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_check(input logic [adr_w-1:0] adr, input logic [cnt_w-1:0] expect_val);
        logic [cnt_w-1:0] got;
        wb_access(1'b0, adr, '0, got);
        assert (got == expect_val) else
            report_fail($sformatf("read of adr %0d gave %0h, expected %0h",
                                  adr, got, expect_val));
    endtask

    // ==================================================================
    // Stream source
    // ==================================================================

    task automatic send_packet(input int beats);
        logic [port_w-1:0] port;
        logic [len_w-1:0]  len;
        stim_seed = xorshift(stim_seed);
        port = stim_seed[port_w-1:0];
        len  = len_w'(stim_seed[13:8]) + 1'b1;    // 1 to 64 bytes.
        for (int i = 0; i < beats; i++) begin
            stim_seed = xorshift(stim_seed);
            in_valid  <= 1'b1;
            in_data   <= stim_seed;
            in_last   <= (i == beats - 1);
            // Body beats carry junk port and length.
            in_port   <= (i == 0) ? port : port_w'(stim_seed[31:16]);
            in_length <= (i == 0) ? len : stim_seed[31:16];
            @(posedge packet_in);
            while (!in_ready) @(posedge packet_in);
        end
        in_valid <= 1'b0;
    endtask

    task automatic send_packets(input int count);
        for (int k = 0; k < count; k++) begin
            stim_seed = xorshift(stim_seed);
            send_packet(int'(stim_seed[15:0] % 6) + 1);
        end
    endtask

    always @(posedge packet_in) begin
        if (random_ready) begin
            ready_seed = xorshift(ready_seed);
            out_ready <= ready_seed[4];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // ==================================================================
    // Reference model and output check
    // ==================================================================

    always @(posedge packet_in) begin
        logic [len_w:0] sum;
        logic           first;
        if (!rst_n) begin
            for (int p = 0; p < num_ports; p++) m_level[p] = '0;
            m_body = 1'b0;
        end else begin
            first = in_valid && in_ready && !m_body;
            sum   = {1'b0, m_level[in_port]} + {1'b0, in_length};
            if (first) begin
                m_port = in_port;
                m_mark = m_en[in_port] && (sum > {1'b0, m_thr[in_port]});
            end
            for (int p = 0; p < num_ports; p++) begin
                if (!m_en[p])
                    m_level[p] = '0;
                else if (first && in_port == port_w'(p) && !m_mark)
                    m_level[p] = drain(sum, m_dec[p]);
                else
                    m_level[p] = drain({1'b0, m_level[p]}, m_dec[p]);
            end
            if (in_valid && in_ready) begin
                if (!m_mark) exp_q.push_back({in_data, in_last, m_port});
                if (in_last) begin
                    if (m_mark) m_drops++;
                    else m_passes++;
                end
                m_body = !in_last;
            end
            // Config follows writes at the acknowledging edge.
            if (wb_cyc && wb_stb && wb_we && !wb_ack) begin
                if (wb_adr < decrement_base) m_en[wb_adr[1:0]] = wb_wdata[0];
                else if (wb_adr < threshold_base) m_dec[wb_adr[1:0]] = wb_wdata[len_w-1:0];
                else if (wb_adr < drop_cnt_adr) m_thr[wb_adr[1:0]] = wb_wdata[len_w-1:0];
            end
        end
    end

    always @(posedge packet_in) begin
        logic [data_w+port_w:0] exp_beat;
        if (rst_n && out_valid && out_ready) begin
            assert (exp_q.size() > 0) else report_fail("output beat with none expected");
            exp_beat = exp_q.pop_front();
            assert ({out_data, out_last, out_port} == exp_beat) else
                report_fail($sformatf("beat data %0h last %0b port %0d, expected %0h",
                                      out_data, out_last, out_port, exp_beat));
        end
    end

    always @(posedge packet_in) begin
        cycles++;
        if (cycles > cycle_lim) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_lim);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        logic [cnt_w-1:0] wv [12];
        packet_in = 1'b0;
        rst_n = 1'b0;
        cycles = 0;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        in_port = '0;
        in_length = '0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_wdata = '0;
        stim_seed = 32'd3;
        ready_seed = 32'd3 ^ 32'h5a5a_0000;
        m_drops = 0;
        m_passes = 0;
        m_mark = 1'b0;
        m_port = '0;
        for (int p = 0; p < num_ports; p++) begin
            m_en[p] = 1'b0;
            m_dec[p] = '0;
            m_thr[p] = '0;
            m_level[p] = '0;
        end
        repeat (8) @(posedge packet_in);
        rst_n <= 1'b1;
        @(posedge packet_in);

        // Register read back and unmapped addresses.
        for (int a = 0; a < 12; a++) begin
            stim_seed = xorshift(stim_seed);
            wv[a] = stim_seed;
            wb_write(adr_w'(a), wv[a]);
        end
        for (int a = 0; a < 12; a++)
            wb_check(adr_w'(a), (a < 4) ? cnt_w'(wv[a][0]) : cnt_w'(wv[a][len_w-1:0]));
        wb_check(4'd14, '0);
        wb_check(4'd15, '0);
        for (int p = 0; p < num_ports; p++) wb_write(enable_base + adr_w'(p), '0);

        // All ports disabled so every packet passes.
        send_packets(20);
        while (exp_q.size() > 0) @(posedge packet_in);
        wb_check(drop_cnt_adr, '0);

        // Small thresholds and a slow drain.
        for (int p = 0; p < num_ports; p++) begin
            stim_seed = xorshift(stim_seed);
            wb_write(decrement_base + adr_w'(p), cnt_w'(stim_seed[1:0]) + 1);
            wb_write(threshold_base + adr_w'(p), cnt_w'(stim_seed[9:4]) + 20);
            wb_write(enable_base + adr_w'(p), 32'd1);
        end
        send_packets(40);

        // Random back-pressure at the output.
        random_ready <= 1'b1;
        send_packets(40);
        while (exp_q.size() > 0) @(posedge packet_in);
        random_ready <= 1'b0;
        @(posedge packet_in);

        wb_check(drop_cnt_adr, cnt_w'(m_drops));
        wb_check(pass_cnt_adr, cnt_w'(m_passes));
        $display("Packets passed %0d, dropped %0d", m_passes, m_drops);
        $display("Verification passed");
        $finish;
    end

endmodule

/* src/policer_top.sv */
// ======================================================================
// Ingress policing stage: config slave, policer and drop filter.
// ======================================================================

`timescale 1ns/10ps

module policer_top
    import policer_pkg::*;
    import policer_regs_pkg::*;
(
    input  logic               packet_in,
    input  logic               rst_n,

    // Input stream.
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [data_w-1:0]  in_data,
    input  logic               in_last,
    input  logic [port_w-1:0]  in_port,
    input  logic [len_w-1:0]   in_length,

    // Output stream.
    output logic               out_valid,
    input  logic               out_ready,
    output logic [data_w-1:0]  out_data,
    output logic               out_last,
    output logic [port_w-1:0]  out_port,

    // Wishbone classic slave.
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [adr_w-1:0]   wb_adr,
    input  logic [cnt_w-1:0]   wb_wdata,
    output logic [cnt_w-1:0]   wb_rdata,
    output logic               wb_ack
);

    logic [num_ports-1:0]       cfg_enable;
    logic [num_ports*len_w-1:0] cfg_decrement;
    logic [num_ports*len_w-1:0] cfg_threshold;

    logic                       pol_valid;
    logic                       pol_ready;
    logic [data_w-1:0]          pol_data;
    logic                       pol_last;
    logic [port_w-1:0]          pol_port;
    logic                       pol_mark;

    logic [cnt_w-1:0]           drop_cnt;
    logic [cnt_w-1:0]           pass_cnt;

    policer_csr u_csr (
        .packet_in, .rst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .drop_cnt, .pass_cnt,
        .cfg_enable, .cfg_decrement, .cfg_threshold
    );

    ingress_policer u_policer (
        .packet_in, .rst_n,
        .cfg_enable, .cfg_decrement, .cfg_threshold,
        .in_valid, .in_ready, .in_data, .in_last, .in_port, .in_length,
        .pol_valid, .pol_ready, .pol_data, .pol_last, .pol_port, .pol_mark
    );

    drop_filter u_filter (
        .packet_in, .rst_n,
        .pol_valid, .pol_ready, .pol_data, .pol_last, .pol_port, .pol_mark,
        .out_valid, .out_ready, .out_data, .out_last, .out_port,
        .drop_cnt, .pass_cnt
    );

endmodule

/* src/drop_filter.sv */
// ======================================================================
// Discards marked packets and counts dropped and passed packets.
// ======================================================================

`timescale 1ns/10ps

module drop_filter
    import policer_pkg::*;
    import policer_regs_pkg::*;
(
    input  logic               packet_in,
    input  logic               rst_n,

    input  logic               pol_valid,
    output logic               pol_ready,
    input  logic [data_w-1:0]  pol_data,
    input  logic               pol_last,
    input  logic [port_w-1:0]  pol_port,
    input  logic               pol_mark,

    output logic               out_valid,
    input  logic               out_ready,
    output logic [data_w-1:0]  out_data,
    output logic               out_last,
    output logic [port_w-1:0]  out_port,

    output logic [cnt_w-1:0]   drop_cnt,
    output logic [cnt_w-1:0]   pass_cnt
);

    logic pkt_done;

    // ==================================================================
    // Data path
    // ==================================================================

    // Marked beats are swallowed at once.
    assign out_valid = pol_valid && !pol_mark;
    assign pol_ready = pol_mark ? 1'b1 : out_ready;

    assign out_data  = pol_data;
    assign out_last  = pol_last;
    assign out_port  = pol_port;

    // ==================================================================
    // Packet counters
    // ==================================================================

    assign pkt_done = pol_valid && pol_ready && pol_last;

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            drop_cnt <= '0;
            pass_cnt <= '0;
        end else if (pkt_done) begin
            if (pol_mark) begin
                drop_cnt <= drop_cnt + 1'b1;
            end else begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    // Mark is stamped on every beat, so a marked packet stays hidden.
    a_marked_hidden: assert property (@(posedge packet_in) disable iff (!rst_n)
        pol_valid && pol_ready && pol_mark && !pol_last |=> !out_valid);

endmodule

/* src/ingress_policer.sv */
// ======================================================================
// Per-port leaky-bucket meters and the marking register slice.
// ======================================================================

`timescale 1ns/10ps

module ingress_policer
    import policer_pkg::*;
(
    input  logic                       packet_in,
    input  logic                       rst_n,

    input  logic [num_ports-1:0]       cfg_enable,
    input  logic [num_ports*len_w-1:0] cfg_decrement,
    input  logic [num_ports*len_w-1:0] cfg_threshold,

    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [data_w-1:0]          in_data,
    input  logic                       in_last,
    input  logic [port_w-1:0]          in_port,
    input  logic [len_w-1:0]           in_length,

    output logic                       pol_valid,
    input  logic                       pol_ready,
    output logic [data_w-1:0]          pol_data,
    output logic                       pol_last,
    output logic [port_w-1:0]          pol_port,
    output logic                       pol_mark
);

    pkt_state_t        pkt_state;
    logic              init_done;       // Holds off the source for one cycle after reset.
    logic              in_accept;
    logic              first_beat;

    logic [len_w-1:0]  level      [num_ports];
    logic [len_w-1:0]  level_next [num_ports];
    logic [len_w:0]    pkt_sum;         // One extra bit, no wrap.
    logic [len_w-1:0]  sel_thr;
    logic              over;
    logic              mark_now;

    logic [port_w-1:0] hold_port;
    logic              hold_mark;

    // Saturating drain of a level.
    function automatic logic [len_w-1:0] sat_sub(input logic [len_w:0]   a,
                                                 input logic [len_w-1:0] b);
        if (a > {1'b0, b}) begin
            return len_w'(a - {1'b0, b});
        end
        return '0;
    endfunction

    // ==================================================================
    // Handshake and packet tracking
    // ==================================================================

    assign in_ready   = init_done && (!pol_valid || pol_ready);
    assign in_accept  = in_valid && in_ready;
    assign first_beat = in_accept && (pkt_state == pkt_idle);

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            init_done <= 1'b0;
            pkt_state <= pkt_idle;
        end else begin
            init_done <= 1'b1;
            if (in_accept) begin
                pkt_state <= in_last ? pkt_idle : pkt_body;
            end
        end
    end

    // ==================================================================
    // Leaky buckets
    // ==================================================================

    assign sel_thr  = cfg_threshold[in_port*len_w +: len_w];
    assign pkt_sum  = {1'b0, level[in_port]} + {1'b0, in_length};
    assign over     = pkt_sum > {1'b0, sel_thr};
    assign mark_now = cfg_enable[in_port] && over;     // Disabled ports never mark.

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            if (!cfg_enable[p]) begin
                level_next[p] = '0;
            end else if (first_beat && (in_port == port_w'(p)) && !over) begin
                level_next[p] = sat_sub(pkt_sum, cfg_decrement[p*len_w +: len_w]);
            end else begin
                // Idle or marked. Drain only.
                level_next[p] = sat_sub({1'b0, level[p]}, cfg_decrement[p*len_w +: len_w]);
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                level[p] <= '0;
            end
        end else begin
            level <= level_next;
        end
    end

    // ==================================================================
    // Output register slice
    // ==================================================================

    // Port and decision of the current packet.
    always_ff @(posedge packet_in) begin
        if (first_beat) begin
            hold_port <= in_port;
            hold_mark <= mark_now;
        end
    end

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            pol_valid <= 1'b0;
        end else if (in_ready) begin
            pol_valid <= in_valid;
        end
    end

    always_ff @(posedge packet_in) begin
        if (in_accept) begin
            pol_data <= in_data;
            pol_last <= in_last;
            pol_port <= first_beat ? in_port : hold_port;
            pol_mark <= first_beat ? mark_now : hold_mark;
        end
    end

    a_stall_stable: assert property (@(posedge packet_in) disable iff (!rst_n)
        pol_valid && !pol_ready |=>
            pol_valid && $stable({pol_data, pol_last, pol_port, pol_mark}));

endmodule

/* src/policer_csr.sv */
// ======================================================================
// Wishbone classic slave for per-port policer config and counters.
// ======================================================================

`timescale 1ns/10ps

module policer_csr
    import policer_pkg::*;
    import policer_regs_pkg::*;
(
    input  logic                       packet_in,
    input  logic                       rst_n,

    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [adr_w-1:0]           wb_adr,
    input  logic [cnt_w-1:0]           wb_wdata,
    output logic [cnt_w-1:0]           wb_rdata,
    output logic                       wb_ack,

    input  logic [cnt_w-1:0]           drop_cnt,
    input  logic [cnt_w-1:0]           pass_cnt,

    output logic [num_ports-1:0]       cfg_enable,
    output logic [num_ports*len_w-1:0] cfg_decrement,
    output logic [num_ports*len_w-1:0] cfg_threshold
);

    reg_sel_t          reg_sel;
    logic [port_w-1:0] port_idx;
    logic              bus_req;     // New request, not yet acknowledged.
    logic [cnt_w-1:0]  rdata_next;

    // ==================================================================
    // Address decode
    // ==================================================================

    always_comb begin
        reg_sel  = reg_none;
        port_idx = '0;
        if (wb_adr < decrement_base) begin
            reg_sel  = reg_enable;
            port_idx = port_w'(wb_adr - enable_base);
        end else if (wb_adr < threshold_base) begin
            reg_sel  = reg_decrement;
            port_idx = port_w'(wb_adr - decrement_base);
        end else if (wb_adr < drop_cnt_adr) begin
            reg_sel  = reg_threshold;
            port_idx = port_w'(wb_adr - threshold_base);
        end else if (wb_adr == drop_cnt_adr) begin
            reg_sel = reg_drop_cnt;
        end else if (wb_adr == pass_cnt_adr) begin
            reg_sel = reg_pass_cnt;
        end
    end

    assign bus_req = wb_cyc && wb_stb && !wb_ack;

    // Single-cycle ack, one cycle after the strobe.
    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_req;
        end
    end

    // ==================================================================
    // Configuration storage
    // ==================================================================

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            cfg_enable    <= '0;
            cfg_decrement <= '0;
            cfg_threshold <= '0;
        end else if (bus_req && wb_we) begin
            case (reg_sel)
                reg_enable:    cfg_enable[port_idx] <= wb_wdata[0];
                reg_decrement: cfg_decrement[port_idx*len_w +: len_w] <= wb_wdata[len_w-1:0];
                reg_threshold: cfg_threshold[port_idx*len_w +: len_w] <= wb_wdata[len_w-1:0];
                default: ;  // Counters are read only.
            endcase
        end
    end

    // Read mux.
    always_comb begin
        case (reg_sel)
            reg_enable:    rdata_next = cnt_w'(cfg_enable[port_idx]);
            reg_decrement: rdata_next = cnt_w'(cfg_decrement[port_idx*len_w +: len_w]);
            reg_threshold: rdata_next = cnt_w'(cfg_threshold[port_idx*len_w +: len_w]);
            reg_drop_cnt:  rdata_next = drop_cnt;
            reg_pass_cnt:  rdata_next = pass_cnt;
            default:       rdata_next = '0;
        endcase
    end

    always_ff @(posedge packet_in) begin
        if (bus_req && !wb_we) begin
            wb_rdata <= rdata_next;     // Valid with wb_ack.
        end
    end

    // ==================================================================
    // Bus protocol checks
    // ==================================================================

    a_ack_one_cycle: assert property (@(posedge packet_in) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

    a_ack_after_stb: assert property (@(posedge packet_in) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

/* src/policer_regs_pkg.sv */
// ======================================================================
// Wishbone register map, register-select enum and counter width.
// ======================================================================

package policer_regs_pkg;

    // Word address width of the configuration slave.
    localparam int adr_w = 4;

    // Dropped and passed packet counters, also the bus data width.
    localparam int cnt_w = 32;

    // ==================================================================
    // Address map
    // ==================================================================

    // One word per port, bit 0 is the enable.
    localparam logic [adr_w-1:0] enable_base = 4'd0;

    // One word per port, drain amount per cycle.
    localparam logic [adr_w-1:0] decrement_base = 4'd4;

    // One word per port, bucket depth threshold.
    localparam logic [adr_w-1:0] threshold_base = 4'd8;

    // Read-only packet counters.
    localparam logic [adr_w-1:0] drop_cnt_adr = 4'd12;
    localparam logic [adr_w-1:0] pass_cnt_adr = 4'd13;

    // ==================================================================
    // Register groups
    // ==================================================================

    typedef enum logic [2:0] {
        reg_enable,
        reg_decrement,
        reg_threshold,
        reg_drop_cnt,
        reg_pass_cnt,
        reg_none        // Unmapped, reads back zero.
    } reg_sel_t;

endpackage

/* src/policer_pkg.sv */
// ======================================================================
// Stream widths, port count, bucket widths and packet-tracking states.
// ======================================================================

package policer_pkg;

    // ==================================================================
    // Ports and stream widths
    // ==================================================================

    // Ingress ports, each with its own leaky bucket.
    localparam int num_ports = 4;

    // Bits needed to carry a port number.
    localparam int port_w = 2;

    // One beat of the packet stream.
    localparam int data_w = 32;

    // ==================================================================
    // Bucket arithmetic
    // ==================================================================

    // Shared by byte length, bucket level, drain amount and threshold.
    localparam int len_w = 16;

    // ==================================================================
    // Packet tracking
    // ==================================================================

    // Tells a packet's first beat apart from its body beats.
    typedef enum logic {
        pkt_idle,   // Next accepted beat opens a packet.
        pkt_body    // Inside a packet, waiting for the last beat.
    } pkt_state_t;

endpackage
